//--- source/tex_defines.svh
/*
 * Texture sampler widths and axis operation codes
 * coordinate, address, texel, tag and cache index sizes
 */

`ifndef TEX_DEFINES_SVH
`define TEX_DEFINES_SVH

// texture dimensions, unsigned
`define TEX_X_W 10
`define TEX_Y_W 9

// byte address and texel payload
`define TEX_ADDR_W  32
`define TEX_TEXEL_W 24
`define TEX_USER_W  8

// direct-mapped L1, one texel per line
`define TEX_IDX_W 6
`define TEX_TAG_W (`TEX_ADDR_W - `TEX_IDX_W - 2)

// per-axis operation
`define TEX_OP_BORDER 2'd0
`define TEX_OP_CLAMP  2'd1
`define TEX_OP_REPEAT 2'd2

`endif

//--- source/tex_pkg.sv
/*
 * Texture sampler types
 * request, response, parameter set and address unit output
 */

`include "tex_defines.svh"

package tex_pkg;

	typedef struct packed {
		logic [`TEX_ADDR_W-1:0]  base;
		logic [`TEX_X_W-1:0]     width;
		logic [`TEX_Y_W-1:0]     height;
		logic [`TEX_ADDR_W-1:0]  stride;
		logic [1:0]              x_op;
		logic [1:0]              y_op;
		logic [`TEX_TEXEL_W-1:0] border_value;
	} tex_param_t;

	// coordinates one bit wider than the texture, signed
	typedef struct packed {
		logic [`TEX_USER_W-1:0]  user;
		logic signed [`TEX_X_W:0] x;
		logic signed [`TEX_Y_W:0] y;
	} tex_req_t;

	typedef struct packed {
		logic [`TEX_USER_W-1:0]  user;
		logic                    border;
		logic [`TEX_TEXEL_W-1:0] data;
	} tex_rsp_t;

	typedef struct packed {
		logic [`TEX_USER_W-1:0] user;
		logic                   border;
		logic [`TEX_ADDR_W-1:0] addr;
	} tex_addr_t;

endpackage

//--- source/axi4_rd_pkg.sv
/*
 * AXI4 read channel types
 * AR and R payloads plus burst and response codes
 */

package axi4_rd_pkg;

	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;

	localparam logic [1:0] AXI_BURST_INCR = 2'b01;
	localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

	typedef struct packed {
		logic [AXI_ADDR_W-1:0] addr;
		logic [7:0]            len;
		logic [2:0]            size;
		logic [1:0]            burst;
	} axi_ar_t;

	typedef struct packed {
		logic [AXI_DATA_W-1:0] data;
		logic [1:0]            resp;
		logic                  last;
	} axi_r_t;

endpackage

//--- source/tex_pipe_slice.sv
/*
 * One-entry valid/ready register slice
 * registered ready, payload type set by parameter
 */

`timescale 1ns/10ps

module tex_pipe_slice #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     arst_n,
	input  payload_t s_data,
	input  logic     s_valid,
	output logic     s_ready,
	output payload_t m_data,
	output logic     m_valid,
	input  logic     m_ready
);

	logic m_valid_next;

	// entry drains on m_ready, fills only when empty
	assign m_valid_next = (m_valid & ~m_ready) | (s_valid & s_ready);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			m_valid <= 1'b0;
			s_ready <= 1'b0;
		end else begin
			m_valid <= m_valid_next;
			s_ready <= ~m_valid_next;
		end
	end

	always_ff @(posedge clk) begin
		if (s_valid && s_ready)
			m_data <= s_data;
	end

	a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
		m_valid && !m_ready |=> m_valid && $stable(m_data))
		else $error("slice payload changed while stalled");

endmodule

//--- source/tex_border_addr_unit.sv
/*
 * Border and address unit
 * per-axis border/clamp/repeat, then base + y*stride + x*4
 * one register stage
 */

`timescale 1ns/10ps

`include "tex_defines.svh"

module tex_border_addr_unit (
	input  logic                clk,
	input  logic                arst_n,
	input  tex_pkg::tex_param_t param,
	input  tex_pkg::tex_req_t   s_req,
	input  logic                s_valid,
	output logic                s_ready,
	output tex_pkg::tex_addr_t  m_addr,
	output logic                m_valid,
	input  logic                m_ready
);

	import tex_pkg::*;

	// common signed width, fits both axes
	localparam int CW = `TEX_X_W + 2;

	// msb of result flags a border hit
	function automatic logic [`TEX_X_W:0] resolve_axis(
		input logic signed [CW-1:0] c,
		input logic [`TEX_X_W-1:0]  size,
		input logic [1:0]           op
	);
		logic signed [CW-1:0] sz;
		logic signed [CW-1:0] w;
		logic [`TEX_X_W:0]    r;
		sz = $signed({2'b00, size});
		w  = (c < 0) ? c + sz : c - sz;
		r  = {1'b0, c[`TEX_X_W-1:0]};
		if (c < 0 || c >= sz) begin
			case (op)
				`TEX_OP_CLAMP:  r = (c < 0) ? '0 : {1'b0, size - 1'b1};
				`TEX_OP_REPEAT: r = {1'b0, w[`TEX_X_W-1:0]};
				default:        r = {1'b1, {`TEX_X_W{1'b0}}};
			endcase
		end
		return r;
	endfunction

	logic signed [CW-1:0] x_ext;
	logic signed [CW-1:0] y_ext;
	logic [`TEX_X_W:0]    x_res;
	logic [`TEX_X_W:0]    y_res;
	tex_addr_t            addr_c;

	assign x_ext = s_req.x;
	assign y_ext = s_req.y;
	assign x_res = resolve_axis(x_ext, param.width, param.x_op);
	assign y_res = resolve_axis(y_ext, `TEX_X_W'(param.height), param.y_op);

	always_comb begin
		addr_c.user   = s_req.user;
		addr_c.border = x_res[`TEX_X_W] | y_res[`TEX_X_W];
		addr_c.addr   = param.base
			+ `TEX_ADDR_W'(y_res[`TEX_Y_W-1:0]) * param.stride
			+ `TEX_ADDR_W'({x_res[`TEX_X_W-1:0], 2'b00});
	end

	// ------------------------------------------------------------
	// output register
	// ------------------------------------------------------------

	assign s_ready = ~m_valid | m_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			m_valid <= 1'b0;
		else if (s_ready)
			m_valid <= s_valid;
	end

	always_ff @(posedge clk) begin
		if (s_valid && s_ready)
			m_addr <= addr_c;
	end

endmodule

//--- source/tex_l1_cache_mem.sv
/*
 * L1 texel cache storage
 * 64 direct-mapped lines of tag and texel, flop valid bits,
 * synchronous read with hit compare on the registered tag
 */

`timescale 1ns/10ps

`include "tex_defines.svh"

module tex_l1_cache_mem (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic [`TEX_IDX_W-1:0]   rd_index,
	input  logic [`TEX_TAG_W-1:0]   rd_tag,
	output logic                    hit,
	output logic [`TEX_TEXEL_W-1:0] rd_data,
	input  logic                    wr_en,
	input  logic [`TEX_IDX_W-1:0]   wr_index,
	input  logic [`TEX_TAG_W-1:0]   wr_tag,
	input  logic [`TEX_TEXEL_W-1:0] wr_data,
	input  logic                    clr_en,
	input  logic [`TEX_IDX_W-1:0]   clr_index
);

	localparam int LINES = 1 << `TEX_IDX_W;

	logic [`TEX_TAG_W-1:0]   tag_mem  [LINES];
	logic [`TEX_TEXEL_W-1:0] data_mem [LINES];
	logic [LINES-1:0]        valid;
	logic                    valid_q;
	logic [`TEX_TAG_W-1:0]   tag_q;
	logic [`TEX_TAG_W-1:0]   rd_tag_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid   <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= valid[rd_index];
			if (wr_en)
				valid[wr_index] <= 1'b1;
			if (clr_en)
				valid[clr_index] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			tag_mem[wr_index]  <= wr_tag;
			data_mem[wr_index] <= wr_data;
		end
		tag_q    <= tag_mem[rd_index];
		rd_data  <= data_mem[rd_index];
		rd_tag_q <= rd_tag;
	end

	assign hit = valid_q && (tag_q == rd_tag_q);

endmodule

//--- source/tex_sampler_ctrl.sv
/*
 * Sampler control FSM
 * cache lookup, single-beat AXI4 miss fetch, line fill,
 * response register and the valid-bit clear walk
 */

`timescale 1ns/10ps

`include "tex_defines.svh"

module tex_sampler_ctrl (
	input  logic                    clk,
	input  logic                    arst_n,
	input  tex_pkg::tex_param_t     param,
	input  tex_pkg::tex_addr_t      s_addr,
	input  logic                    s_valid,
	output logic                    s_ready,
	output logic [`TEX_IDX_W-1:0]   rd_index,
	output logic [`TEX_TAG_W-1:0]   rd_tag,
	input  logic                    hit,
	input  logic [`TEX_TEXEL_W-1:0] rd_data,
	output logic                    wr_en,
	output logic [`TEX_IDX_W-1:0]   wr_index,
	output logic [`TEX_TAG_W-1:0]   wr_tag,
	output logic [`TEX_TEXEL_W-1:0] wr_data,
	output logic                    clr_en,
	output logic [`TEX_IDX_W-1:0]   clr_index,
	input  logic                    clear_start,
	output logic                    clear_busy,
	output tex_pkg::tex_rsp_t       m_rsp,
	output logic                    m_valid,
	input  logic                    m_ready,
	output axi4_rd_pkg::axi_ar_t    m_axi_ar,
	output logic                    m_axi_arvalid,
	input  logic                    m_axi_arready,
	input  axi4_rd_pkg::axi_r_t     m_axi_r,
	input  logic                    m_axi_rvalid,
	output logic                    m_axi_rready
);

	import tex_pkg::*;
	import axi4_rd_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_FETCH_AR,
		ST_FETCH_R,
		ST_RESPOND,
		ST_CLEAR
	} state_t;

	state_t                state;
	tex_addr_t             req_q;
	logic [`TEX_IDX_W-1:0] clr_cnt;

	assign s_ready = (state == ST_IDLE) && !clear_busy && !clear_start;

	// read issued in the accept cycle, result seen in LOOKUP
	assign rd_index = s_addr.addr[`TEX_IDX_W+1:2];
	assign rd_tag   = s_addr.addr[`TEX_ADDR_W-1:`TEX_IDX_W+2];

	// line fill from the R beat
	assign wr_en    = (state == ST_FETCH_R) && m_axi_rvalid && (m_axi_r.resp == AXI_RESP_OKAY);
	assign wr_index = req_q.addr[`TEX_IDX_W+1:2];
	assign wr_tag   = req_q.addr[`TEX_ADDR_W-1:`TEX_IDX_W+2];
	assign wr_data  = m_axi_r.data[`TEX_TEXEL_W-1:0];

	assign clr_en    = (state == ST_CLEAR);
	assign clr_index = clr_cnt;

	assign m_axi_rready = (state == ST_FETCH_R);

	always_comb begin
		m_axi_ar.addr  = {req_q.addr[`TEX_ADDR_W-1:2], 2'b00};
		m_axi_ar.len   = 8'd0;
		m_axi_ar.size  = 3'd2;
		m_axi_ar.burst = AXI_BURST_INCR;
	end

	// ------------------------------------------------------------
	// state machine
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state         <= ST_IDLE;
			m_valid       <= 1'b0;
			m_axi_arvalid <= 1'b0;
			clear_busy    <= 1'b0;
			clr_cnt       <= '0;
		end else begin
			if (clear_start)
				clear_busy <= 1'b1;
			case (state)
				ST_IDLE: begin
					if (clear_start || clear_busy)
						state <= ST_CLEAR;
					else if (s_valid)
						state <= ST_LOOKUP;
				end
				ST_LOOKUP: begin
					if (req_q.border || hit) begin
						m_valid <= 1'b1;
						state   <= ST_RESPOND;
					end else begin
						m_axi_arvalid <= 1'b1;
						state         <= ST_FETCH_AR;
					end
				end
				ST_FETCH_AR: begin
					if (m_axi_arready) begin
						m_axi_arvalid <= 1'b0;
						state         <= ST_FETCH_R;
					end
				end
				ST_FETCH_R: begin
					if (m_axi_rvalid) begin
						m_valid <= 1'b1;
						state   <= ST_RESPOND;
					end
				end
				ST_RESPOND: begin
					if (m_ready) begin
						m_valid <= 1'b0;
						state   <= ST_IDLE;
					end
				end
				ST_CLEAR: begin
					clr_cnt <= clr_cnt + 1'b1;
					// last line, a new start restarts the walk
					if (&clr_cnt) begin
						clear_busy <= clear_start;
						state      <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (s_valid && s_ready)
			req_q <= s_addr;
		if (state == ST_LOOKUP) begin
			m_rsp.user   <= req_q.user;
			m_rsp.border <= req_q.border;
			m_rsp.data   <= req_q.border ? param.border_value : rd_data;
		end
		if (state == ST_FETCH_R && m_axi_rvalid)
			m_rsp.data <= m_axi_r.data[`TEX_TEXEL_W-1:0];
	end

	a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
		m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_ar))
		else $error("AR dropped or changed before arready");

	a_r_last: assert property (@(posedge clk) disable iff (!arst_n)
		m_axi_rvalid && m_axi_rready |-> m_axi_r.last)
		else $error("R beat without last on single-beat burst");

endmodule

//--- source/tex_sampler_top.sv
/*
 * 2D nearest-neighbour texture sampler
 * request slice, border/address unit, L1 cache, control FSM
 * and response slice, misses fetched over AXI4 read
 */

`timescale 1ns/10ps

`include "tex_defines.svh"

module tex_sampler_top (
	input  logic                 clk,
	input  logic                 arst_n,
	input  tex_pkg::tex_param_t  param,
	input  logic                 clear_start,
	output logic                 clear_busy,
	input  tex_pkg::tex_req_t    s_req,
	input  logic                 s_valid,
	output logic                 s_ready,
	output tex_pkg::tex_rsp_t    m_rsp,
	output logic                 m_valid,
	input  logic                 m_ready,
	output axi4_rd_pkg::axi_ar_t m_axi_ar,
	output logic                 m_axi_arvalid,
	input  logic                 m_axi_arready,
	input  axi4_rd_pkg::axi_r_t  m_axi_r,
	input  logic                 m_axi_rvalid,
	output logic                 m_axi_rready
);

	import tex_pkg::*;

	tex_req_t  req;
	logic      req_valid;
	logic      req_ready;
	tex_addr_t addr;
	logic      addr_valid;
	logic      addr_ready;
	tex_rsp_t  rsp;
	logic      rsp_valid;
	logic      rsp_ready;

	// cache port
	logic [`TEX_IDX_W-1:0]   rd_index;
	logic [`TEX_TAG_W-1:0]   rd_tag;
	logic                    hit;
	logic [`TEX_TEXEL_W-1:0] rd_data;
	logic                    wr_en;
	logic [`TEX_IDX_W-1:0]   wr_index;
	logic [`TEX_TAG_W-1:0]   wr_tag;
	logic [`TEX_TEXEL_W-1:0] wr_data;
	logic                    clr_en;
	logic [`TEX_IDX_W-1:0]   clr_index;

	tex_pipe_slice #(.payload_t(tex_req_t)) u_req_slice (
		.clk     (clk),
		.arst_n  (arst_n),
		.s_data  (s_req),
		.s_valid (s_valid),
		.s_ready (s_ready),
		.m_data  (req),
		.m_valid (req_valid),
		.m_ready (req_ready)
	);

	tex_border_addr_unit u_addr (
		.clk     (clk),
		.arst_n  (arst_n),
		.param   (param),
		.s_req   (req),
		.s_valid (req_valid),
		.s_ready (req_ready),
		.m_addr  (addr),
		.m_valid (addr_valid),
		.m_ready (addr_ready)
	);

	tex_l1_cache_mem u_l1 (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd_index  (rd_index),
		.rd_tag    (rd_tag),
		.hit       (hit),
		.rd_data   (rd_data),
		.wr_en     (wr_en),
		.wr_index  (wr_index),
		.wr_tag    (wr_tag),
		.wr_data   (wr_data),
		.clr_en    (clr_en),
		.clr_index (clr_index)
	);

	tex_sampler_ctrl u_ctrl (
		.clk           (clk),
		.arst_n        (arst_n),
		.param         (param),
		.s_addr        (addr),
		.s_valid       (addr_valid),
		.s_ready       (addr_ready),
		.rd_index      (rd_index),
		.rd_tag        (rd_tag),
		.hit           (hit),
		.rd_data       (rd_data),
		.wr_en         (wr_en),
		.wr_index      (wr_index),
		.wr_tag        (wr_tag),
		.wr_data       (wr_data),
		.clr_en        (clr_en),
		.clr_index     (clr_index),
		.clear_start   (clear_start),
		.clear_busy    (clear_busy),
		.m_rsp         (rsp),
		.m_valid       (rsp_valid),
		.m_ready       (rsp_ready),
		.m_axi_ar      (m_axi_ar),
		.m_axi_arvalid (m_axi_arvalid),
		.m_axi_arready (m_axi_arready),
		.m_axi_r       (m_axi_r),
		.m_axi_rvalid  (m_axi_rvalid),
		.m_axi_rready  (m_axi_rready)
	);

	tex_pipe_slice #(.payload_t(tex_rsp_t)) u_rsp_slice (
		.clk     (clk),
		.arst_n  (arst_n),
		.s_data  (rsp),
		.s_valid (rsp_valid),
		.s_ready (rsp_ready),
		.m_data  (m_rsp),
		.m_valid (m_valid),
		.m_ready (m_ready)
	);

endmodule

//--- sim/tb_axi_mem_model.sv
/*
 * AXI4 read slave model for the sampler testbench
 * single outstanding read, word = address xor 5a5a5a5a,
 * random arready and rvalid stalls
 */

`timescale 1ns/10ps

module tb_axi_mem_model #(
	parameter int SEED = 32'h057f4324
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  axi4_rd_pkg::axi_ar_t ar,
	input  logic                 arvalid,
	output logic                 arready,
	output axi4_rd_pkg::axi_r_t  r,
	output logic                 rvalid,
	input  logic                 rready
);

	import axi4_rd_pkg::*;

	int                    seed;
	logic                  pending;
	logic [AXI_ADDR_W-1:0] addr_q;

	initial begin
		seed    = SEED;
		arready <= 1'b0;
		rvalid  <= 1'b0;
		r       <= '0;
	end

	// handshakes land on the rising edge
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pending <= 1'b0;
		end else if (arvalid && arready) begin
			pending <= 1'b1;
			addr_q  <= ar.addr;
		end else if (rvalid && rready) begin
			pending <= 1'b0;
		end
	end

	// outputs change on the falling edge
	always @(negedge clk) begin
		if (!arst_n || !pending) begin
			rvalid  <= 1'b0;
			arready <= arst_n && (($random(seed) & 1) != 0);
		end else begin
			arready <= 1'b0;
			if (!rvalid)
				rvalid <= (($random(seed) & 1) != 0);
			r.data <= addr_q ^ 32'h5a5a5a5a;
			r.resp <= AXI_RESP_OKAY;
			r.last <= 1'b1;
		end
	end

endmodule

//--- sim/tb_tex_sampler.sv
/*
 * Texture sampler testbench
 * in-range, border, clamp/repeat, hit, clear and back-pressure runs,
 * results checked by concurrent assertions against expected texels
 */

`timescale 1ns/10ps

`include "tex_defines.svh"

module tb_tex_sampler;

	import tex_pkg::*;
	import axi4_rd_pkg::*;

	localparam int SEED    = 32'h057f4324;
	localparam int TIMEOUT = 2000;

	logic       clk;
	logic       arst_n;
	tex_param_t param;
	logic       clear_start;
	logic       clear_busy;
	tex_req_t   s_req;
	logic       s_valid;
	logic       s_ready;
	tex_rsp_t   m_rsp;
	logic       m_valid;
	logic       m_ready;
	axi_ar_t    ar;
	logic       arvalid;
	logic       arready;
	axi_r_t     r;
	logic       rvalid;
	logic       rready;

	// expected responses in request order
	tex_rsp_t               exp_mem [64];
	tex_rsp_t               exp_head;
	int                     wr_ptr;
	int                     rd_ptr;
	int                     ar_cnt;
	int                     ar_start;
	int                     ar_expect;
	logic                   ar_check;
	logic                   stall_en;
	int                     seed;
	int                     err_cnt;
	int                     err_start;
	int                     tests;
	logic [`TEX_USER_W-1:0] tag;
	string                  test_name;

	tex_sampler_top dut0 (
		.clk           (clk),
		.arst_n        (arst_n),
		.param         (param),
		.clear_start   (clear_start),
		.clear_busy    (clear_busy),
		.s_req         (s_req),
		.s_valid       (s_valid),
		.s_ready       (s_ready),
		.m_rsp         (m_rsp),
		.m_valid       (m_valid),
		.m_ready       (m_ready),
		.m_axi_ar      (ar),
		.m_axi_arvalid (arvalid),
		.m_axi_arready (arready),
		.m_axi_r       (r),
		.m_axi_rvalid  (rvalid),
		.m_axi_rready  (rready)
	);

	tb_axi_mem_model #(.SEED(SEED)) u_mem (
		.clk     (clk),
		.arst_n  (arst_n),
		.ar      (ar),
		.arvalid (arvalid),
		.arready (arready),
		.r       (r),
		.rvalid  (rvalid),
		.rready  (rready)
	);

	always #10 clk = ~clk;

	always @(negedge clk)
		m_ready <= !stall_en || (($random(seed) & 1) != 0);

	assign exp_head = exp_mem[rd_ptr];

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr <= 0;
			ar_cnt <= 0;
		end else begin
			if (m_valid && m_ready)
				rd_ptr <= rd_ptr + 1;
			if (arvalid && arready)
				ar_cnt <= ar_cnt + 1;
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------

	a_rsp_value: assert property (@(posedge clk) disable iff (!arst_n)
		m_valid && m_ready |-> m_rsp == exp_head)
		else begin
			$display("ERROR %s: response expected %h actual %h", test_name,
				$sampled(exp_head), $sampled(m_rsp));
			err_cnt = err_cnt + 1;
		end

	a_rsp_known: assert property (@(posedge clk) disable iff (!arst_n)
		m_valid |-> rd_ptr < wr_ptr)
		else begin
			$display("%s: response arrived with no request outstanding", test_name);
			err_cnt = err_cnt + 1;
		end

	a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
		m_valid && !m_ready |=> m_valid && $stable(m_rsp))
		else begin
			$display("%s: response changed or dropped while m_ready was low", test_name);
			err_cnt = err_cnt + 1;
		end

	a_ar_count: assert property (@(posedge clk) disable iff (!arst_n)
		ar_check |-> ar_cnt - ar_start == ar_expect)
		else begin
			$display("ERROR %s: AR handshakes expected %0d actual %0d", test_name,
				ar_expect, $sampled(ar_cnt) - ar_start);
			err_cnt = err_cnt + 1;
		end

	a_ar_fields: assert property (@(posedge clk) disable iff (!arst_n)
		arvalid |-> ar.len == 8'd0 && ar.size == 3'd2 && ar.burst == AXI_BURST_INCR)
		else begin
			$display("%s: read burst is not a single word INCR beat", test_name);
			err_cnt = err_cnt + 1;
		end

	a_clear_rise: assert property (@(posedge clk) disable iff (!arst_n)
		clear_start && !clear_busy |=> clear_busy)
		else begin
			$display("%s: clear_busy did not rise after clear_start", test_name);
			err_cnt = err_cnt + 1;
		end

	// ------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------

	task automatic report_timeout(input string what);
		$display("%s: %s", test_name, what);
		err_cnt = err_cnt + 1;
	endtask

	// texel the memory holds at a texture coordinate
	function automatic logic [`TEX_TEXEL_W-1:0] mem_texel(input int tx, input int ty);
		logic [`TEX_ADDR_W-1:0] a;
		a = param.base + ty * param.stride + tx * 4;
		return a[`TEX_TEXEL_W-1:0] ^ 24'h5a5a5a;
	endfunction

	task automatic send_req(input int x, input int y, input tex_rsp_t e);
		int t;
		t = 0;
		exp_mem[wr_ptr] = e;
		wr_ptr     = wr_ptr + 1;
		s_req.user = e.user;
		s_req.x    = x[`TEX_X_W:0];
		s_req.y    = y[`TEX_Y_W:0];
		s_valid    = 1'b1;
		tag        = tag + 1'b1;
		while (!s_ready && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (!s_ready)
			report_timeout("timeout waiting for the sampler to accept a request");
		@(negedge clk);
		s_valid = 1'b0;
	endtask

	// (tx, ty) is the texel that (x, y) resolves to
	task automatic sample(input int x, input int y, input int tx, input int ty);
		tex_rsp_t e;
		e.user   = tag;
		e.border = 1'b0;
		e.data   = mem_texel(tx, ty);
		send_req(x, y, e);
	endtask

	task automatic sample_border(input int x, input int y);
		tex_rsp_t e;
		e.user   = tag;
		e.border = 1'b1;
		e.data   = param.border_value;
		send_req(x, y, e);
	endtask

	task automatic wait_drained();
		int t;
		t = 0;
		while (rd_ptr != wr_ptr && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (rd_ptr != wr_ptr)
			report_timeout("timeout waiting for outstanding responses");
	endtask

	task automatic wait_clear(input logic level);
		int t;
		t = 0;
		while (clear_busy != level && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (clear_busy != level)
			report_timeout("timeout waiting for clear_busy to change");
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_start = err_cnt;
		ar_start  = ar_cnt;
	endtask

	task automatic end_test(input logic check_ar, input int ar_want);
		wait_drained();
		if (check_ar) begin
			ar_expect = ar_want;
			ar_check  = 1'b1;
			@(negedge clk);
			ar_check  = 1'b0;
		end
		$display("test %s: done, %0d errors", test_name, err_cnt - err_start);
		tests = tests + 1;
	endtask

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------

	initial begin
		clk                = 1'b0;
		arst_n             = 1'b0;
		clear_start        = 1'b0;
		s_req              = '0;
		s_valid            = 1'b0;
		m_ready            <= 1'b1;
		stall_en           = 1'b0;
		ar_check           = 1'b0;
		ar_expect          = 0;
		seed               = SEED;
		wr_ptr             = 0;
		err_cnt            = 0;
		tests              = 0;
		tag                = '0;
		test_name          = "reset";
		param.base         = 32'h0001_0000;
		param.width        = 64;
		param.height       = 32;
		param.stride       = 256;
		param.x_op         = `TEX_OP_BORDER;
		param.y_op         = `TEX_OP_BORDER;
		param.border_value = 24'hc0ffee;
		repeat (5) @(negedge clk);
		arst_n = 1'b1;

		start_test("in_range");
		sample(5, 3, 5, 3);
		sample(63, 31, 63, 31);
		end_test(1'b1, 2);

		start_test("border");
		sample_border(-1, 2);
		sample_border(64, 0);
		sample_border(3, 32);
		end_test(1'b1, 0);

		// lines 0 and 63 refilled so all three miss
		start_test("clamp_repeat");
		param.x_op = `TEX_OP_CLAMP;
		param.y_op = `TEX_OP_REPEAT;
		sample(-5, -3, 0, 29);
		sample(100, 40, 63, 8);
		sample(70, -32, 63, 0);
		end_test(1'b1, 3);
		param.x_op = `TEX_OP_BORDER;
		param.y_op = `TEX_OP_BORDER;

		start_test("hit");
		sample(5, 3, 5, 3);
		sample(5, 3, 5, 3);
		end_test(1'b1, 0);

		start_test("clear");
		clear_start = 1'b1;
		@(negedge clk);
		clear_start = 1'b0;
		wait_clear(1'b1);
		wait_clear(1'b0);
		sample(5, 3, 5, 3);
		sample(5, 3, 5, 3);
		end_test(1'b1, 1);

		start_test("stall_order");
		stall_en = 1'b1;
		sample(1, 1, 1, 1);
		sample(1, 1, 1, 1);
		sample_border(-2, 0);
		sample(7, 30, 7, 30);
		sample(1, 1, 1, 1);
		sample_border(600, 2);
		sample(2, 2, 2, 2);
		sample(7, 30, 7, 30);
		end_test(1'b0, 0);
		stall_en = 1'b0;

		$display("tests run %0d, errors %0d", tests, err_cnt);
		if (err_cnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- build.f
+incdir+source
source/tex_pkg.sv
source/axi4_rd_pkg.sv
source/tex_pipe_slice.sv
source/tex_border_addr_unit.sv
source/tex_l1_cache_mem.sv
source/tex_sampler_ctrl.sv
source/tex_sampler_top.sv
sim/tb_axi_mem_model.sv
sim/tb_tex_sampler.sv

//--- run_sim.sh
#!/bin/sh
# build the texture sampler testbench with Verilator and run it
verilator --binary --assert -Wno-fatal -f build.f --top-module tb_tex_sampler || exit 1
out=$(./obj_dir/Vtb_tex_sampler)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'PASS: all tests' && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}
